//--- hdl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath widths
`define RV_XLEN         64          // register and data bus width
`define RV_ADDR_W       64          // pc and bus address width
`define RV_ILEN         32          // instruction word

// reset state
`define RV_RESET_PC     64'h1000    // first fetch
`define RV_TRAP_BASE    64'h100     // mtvec after reset
`define RV_NOP          32'h0000_0013   // addi x0, x0, 0

// machine csr numbers
`define RV_CSR_MSTATUS  12'h300
`define RV_CSR_MTVEC    12'h305
`define RV_CSR_MEPC     12'h341
`define RV_CSR_MCAUSE   12'h342

`define RV_FUNCT12_MRET 12'h302     // imm field of mret
`define RV_CAUSE_MEXT   63'd11      // machine external interrupt

`endif

//--- hdl/rv_pkg.sv
package rv_pkg;

    // major opcodes the core knows, anything else is a no-op
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_SYSTEM = 7'b1110011
    } rv_opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_type_t;

    typedef struct packed {
        logic [11:0] imm;     // also csr number / funct12
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;   // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;   // imm[4:0]
        logic [6:0] opcode;
    } rv_s_type_t;

    typedef struct packed {
        logic [19:0] imm;     // imm[31:12]
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_type_t;

    // one fetched word, four views
    typedef union packed {
        rv_r_type_t r_type;
        rv_i_type_t i_type;
        rv_s_type_t s_type;
        rv_u_type_t u_type;
    } rv_instr_u;

    typedef struct packed {
        logic        irq;     // bit 63, interrupt vs exception
        logic [62:0] code;
    } rv_mcause_t;

endpackage

//--- hdl/rv_mem_if.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

// single outstanding data access, core side to bus master
interface rv_mem_if;
    logic                  req;     // one-cycle pulse
    logic                  we;      // 1 = store
    logic [`RV_ADDR_W-1:0] addr;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_XLEN-1:0]   rdata;   // valid with done on a read
    logic                  done;    // one-cycle pulse

    modport core (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport master (
        input  req, we, addr, wdata,
        output rdata, done
    );
endinterface

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    input  logic                rd_we,
    input  logic [4:0]          rd_addr,
    input  logic [`RV_XLEN-1:0] rd_data
);
    logic [`RV_XLEN-1:0] regs [32];

    // write port, x0 never written
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // combinational reads
    assign rs1_data = regs[rs1_addr];   // x0 keeps its reset zero
    assign rs2_data = regs[rs2_addr];

endmodule

//--- hdl/rv_csr.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_csr (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [11:0]           csr_addr,
    input  logic                  csr_we,
    input  logic [`RV_XLEN-1:0]   csr_wdata,
    output logic [`RV_XLEN-1:0]   csr_rdata,
    input  logic                  trap_take,
    input  logic [`RV_ADDR_W-1:0] trap_pc,
    input  logic                  mret,
    output logic                  mie,
    output logic [`RV_ADDR_W-1:0] mtvec,
    output logic [`RV_ADDR_W-1:0] mepc
);
    import rv_pkg::*;

    logic       mpie;       // mstatus[7]
    rv_mcause_t mcause;

    // read mux, unknown numbers read zero
    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            `RV_CSR_MSTATUS: begin
                csr_rdata[3] = mie;
                csr_rdata[7] = mpie;
            end
            `RV_CSR_MTVEC:  csr_rdata = mtvec;
            `RV_CSR_MEPC:   csr_rdata = mepc;
            `RV_CSR_MCAUSE: csr_rdata = mcause;
            default:        csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mie    <= 1'b0;
            mpie   <= 1'b0;
            mtvec  <= `RV_TRAP_BASE;
            mepc   <= '0;
            mcause <= '0;
        end else if (trap_take) begin   // same edge as the pc redirect
            mepc        <= trap_pc;
            mcause.irq  <= 1'b1;
            mcause.code <= `RV_CAUSE_MEXT;
            mpie        <= mie;
            mie         <= 1'b0;        // handler runs masked
        end else if (mret) begin
            mie  <= mpie;
            mpie <= 1'b1;
        end else if (csr_we) begin
            case (csr_addr)
                `RV_CSR_MSTATUS: begin
                    mie  <= csr_wdata[3];
                    mpie <= csr_wdata[7];
                end
                `RV_CSR_MTVEC:  mtvec  <= {csr_wdata[`RV_XLEN-1:2], 2'b00}; // direct mode
                `RV_CSR_MEPC:   mepc   <= {csr_wdata[`RV_XLEN-1:2], 2'b00};
                `RV_CSR_MCAUSE: mcause <= csr_wdata;
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`RV_ADDR_W-1:0] imem_addr,
    input  logic [`RV_ILEN-1:0]   imem_data,
    input  logic                  irq,
    output logic                  irq_ack,
    rv_mem_if.core                mem,
    output logic [4:0]            rs1_addr,
    output logic [4:0]            rs2_addr,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    output logic                  rd_we,
    output logic [4:0]            rd_addr,
    output logic [`RV_XLEN-1:0]   rd_data,
    output logic [11:0]           csr_addr,
    output logic                  csr_we,
    output logic [`RV_XLEN-1:0]   csr_wdata,
    input  logic [`RV_XLEN-1:0]   csr_rdata,
    output logic                  trap_take,
    output logic [`RV_ADDR_W-1:0] trap_pc,
    output logic                  mret,
    input  logic                  mie,
    input  logic [`RV_ADDR_W-1:0] mtvec,
    input  logic [`RV_ADDR_W-1:0] mepc
);
    import rv_pkg::*;

    logic [`RV_ADDR_W-1:0] pc;          // fetch address, ir sits at pc-4
    rv_instr_u             ir;
    logic                  bubble;      // ir is wrong-path, drop it
    logic                  mem_wait;    // ld/sd in flight
    rv_opcode_e            op;
    logic [`RV_XLEN-1:0]   imm_i;
    logic [`RV_XLEN-1:0]   imm_s;
    logic [`RV_XLEN-1:0]   imm_u;
    logic                  is_addi;
    logic                  is_add;
    logic                  is_load;
    logic                  is_store;
    logic                  is_csrrw;
    logic                  is_mret;
    logic                  take_irq;
    logic                  exec;

    assign imem_addr = pc;

    // decode, same word through every view
    assign op    = rv_opcode_e'(ir.r_type.opcode);
    assign imm_i = {{(`RV_XLEN-12){ir.i_type.imm[11]}}, ir.i_type.imm};
    assign imm_s = {{(`RV_XLEN-12){ir.s_type.imm_hi[6]}}, ir.s_type.imm_hi, ir.s_type.imm_lo};
    assign imm_u = {{(`RV_XLEN-32){ir.u_type.imm[19]}}, ir.u_type.imm, 12'b0};

    assign is_addi  = (op == OP_IMM) && (ir.i_type.funct3 == 3'b000);
    assign is_add   = (op == OP_REG) && (ir.r_type.funct3 == 3'b000)
                      && (ir.r_type.funct7 == 7'd0);
    assign is_load  = (op == OP_LOAD) && (ir.i_type.funct3 == 3'b011);    // ld only
    assign is_store = (op == OP_STORE) && (ir.s_type.funct3 == 3'b011);   // sd only
    assign is_csrrw = (op == OP_SYSTEM) && (ir.i_type.funct3 == 3'b001);
    assign is_mret  = (op == OP_SYSTEM) && (ir.i_type.funct3 == 3'b000)
                      && (ir.i_type.imm == `RV_FUNCT12_MRET);

    // interrupt wins over the word in ir, never mid-access or in a bubble
    assign take_irq = irq && mie && !mem_wait && !bubble;
    assign exec     = !bubble && !mem_wait && !take_irq;

    assign trap_take = take_irq;
    assign trap_pc   = pc - 4;              // address of the skipped instruction
    assign mret      = exec && is_mret;

    // register file side
    assign rs1_addr = ir.r_type.rs1;
    assign rs2_addr = ir.r_type.rs2;
    assign rd_addr  = ir.r_type.rd;

    // csrrw swaps rs1 into the csr
    assign csr_addr  = ir.i_type.imm;
    assign csr_we    = exec && is_csrrw;
    assign csr_wdata = rs1_data;

    // memory request, ir and regs frozen so these hold until done
    assign mem.req   = exec && (is_load || is_store);
    assign mem.we    = is_store;
    assign mem.addr  = rs1_data + (is_store ? imm_s : imm_i);
    assign mem.wdata = rs2_data;

    // writeback
    always_comb begin
        rd_we   = 1'b0;
        rd_data = '0;
        if (mem_wait) begin
            rd_we   = mem.done && is_load;  // ld lands in the done cycle
            rd_data = mem.rdata;
        end else if (exec) begin
            if (op == OP_LUI) begin
                rd_we   = 1'b1;
                rd_data = imm_u;
            end else if (is_addi) begin
                rd_we   = 1'b1;
                rd_data = rs1_data + imm_i;
            end else if (is_add) begin
                rd_we   = 1'b1;
                rd_data = rs1_data + rs2_data;
            end else if (is_csrrw) begin
                rd_we   = 1'b1;
                rd_data = csr_rdata;        // old value
            end
        end
    end

    // fetch, redirect and stall
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc       <= `RV_RESET_PC;
            ir       <= `RV_NOP;
            bubble   <= 1'b0;
            mem_wait <= 1'b0;
            irq_ack  <= 1'b0;
        end else begin
            irq_ack <= take_irq;
            if (take_irq || mret) begin
                pc     <= take_irq ? mtvec : mepc;
                ir     <= imem_data;        // wrong path, flushed next cycle
                bubble <= 1'b1;
            end else if (mem.req) begin
                mem_wait <= 1'b1;           // hold pc and ir
            end else if (mem_wait) begin
                if (mem.done) begin
                    mem_wait <= 1'b0;
                    pc       <= pc + 4;
                    ir       <= imem_data;
                end
            end else begin
                pc     <= pc + 4;
                ir     <= imem_data;
                bubble <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/rv_axil_master.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_axil_master (
    input  logic                     clk,
    input  logic                     reset,
    rv_mem_if.master                 mem,
    output logic [`RV_ADDR_W-1:0]    araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [`RV_XLEN-1:0]      rdata,
    input  logic [1:0]               rresp,
    input  logic                     rvalid,
    output logic                     rready,
    output logic [`RV_ADDR_W-1:0]    awaddr,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [`RV_XLEN-1:0]      wdata,
    output logic [`RV_XLEN/8-1:0]    wstrb,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic [1:0]               bresp,
    input  logic                     bvalid,
    output logic                     bready
);
    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_RESP} state_e;

    state_e                state;
    logic                  we_q;        // current access is a write
    logic                  done_q;
    logic [`RV_ADDR_W-1:0] addr_q;
    logic [`RV_XLEN-1:0]   wdata_q;
    logic [`RV_XLEN-1:0]   rdata_q;

    assign araddr  = addr_q;
    assign awaddr  = addr_q;
    assign wdata   = wdata_q;
    assign wstrb   = '1;                    // full 64-bit writes only
    assign rready  = (state == ST_RESP) && !we_q;
    assign bready  = (state == ST_RESP) && we_q;
    assign mem.rdata = rdata_q;
    assign mem.done  = done_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= ST_IDLE;
            we_q    <= 1'b0;
            done_q  <= 1'b0;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: if (mem.req) begin
                    we_q    <= mem.we;
                    arvalid <= !mem.we;
                    awvalid <= mem.we;      // aw and w raised together
                    wvalid  <= mem.we;
                    state   <= ST_ADDR;
                end
                ST_ADDR: if (we_q) begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    // both accepted, in either order
                    if ((!awvalid || awready) && (!wvalid || wready)) state <= ST_RESP;
                end else if (arready) begin
                    arvalid <= 1'b0;
                    state   <= ST_RESP;
                end
                ST_RESP: if ((we_q && bvalid) || (!we_q && rvalid)) begin
                    done_q <= 1'b1;         // rresp/bresp not checked
                    state  <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload, latched at request and at read response
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && mem.req) begin
            addr_q  <= mem.addr;
            wdata_q <= mem.wdata;
        end
        if (rvalid && rready) rdata_q <= rdata;
    end

endmodule

//--- hdl/rv_top.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_top (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`RV_ADDR_W-1:0] imem_addr,
    input  logic [`RV_ILEN-1:0]   imem_data,
    input  logic                  irq,
    output logic                  irq_ack,
    output logic [`RV_ADDR_W-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [`RV_XLEN-1:0]   rdata,
    input  logic [1:0]            rresp,
    input  logic                  rvalid,
    output logic                  rready,
    output logic [`RV_ADDR_W-1:0] awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [`RV_XLEN-1:0]   wdata,
    output logic [`RV_XLEN/8-1:0] wstrb,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic [1:0]            bresp,
    input  logic                  bvalid,
    output logic                  bready
);
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic                  rd_we;
    logic [4:0]            rd_addr;
    logic [`RV_XLEN-1:0]   rd_data;
    logic [11:0]           csr_addr;
    logic                  csr_we;
    logic [`RV_XLEN-1:0]   csr_wdata;
    logic [`RV_XLEN-1:0]   csr_rdata;
    logic                  trap_take;
    logic [`RV_ADDR_W-1:0] trap_pc;
    logic                  mret;
    logic                  mie;
    logic [`RV_ADDR_W-1:0] mtvec;
    logic [`RV_ADDR_W-1:0] mepc;

    rv_mem_if mem_bus ();   // core to axi master

    rv_core rv_core_inst (
        .clk, .reset, .imem_addr, .imem_data, .irq, .irq_ack,
        .mem       (mem_bus.core),
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rd_we, .rd_addr, .rd_data,
        .csr_addr, .csr_we, .csr_wdata, .csr_rdata,
        .trap_take, .trap_pc, .mret, .mie, .mtvec, .mepc
    );

    rv_regfile rv_regfile_inst (
        .clk, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rd_we, .rd_addr, .rd_data
    );

    rv_csr rv_csr_inst (
        .clk, .reset, .csr_addr, .csr_we, .csr_wdata, .csr_rdata,
        .trap_take, .trap_pc, .mret, .mie, .mtvec, .mepc
    );

    rv_axil_master rv_axil_master_inst (
        .clk, .reset,
        .mem       (mem_bus.master),
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready
    );

endmodule

//--- bench/rv_axil_ram.sv
`timescale 1ns/1ps

// axi4-lite slave memory, 256 x 64 bit, random ready stalls
module rv_axil_ram #(
    parameter logic [31:0] SEED = 32'd56
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [63:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [63:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic [63:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [63:0] wdata,
    input  logic [7:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic        preload_we,     // backdoor load from the testbench
    input  logic [7:0]  preload_addr,
    input  logic [63:0] preload_data
);
    logic [63:0] mem [256];
    logic        written [256];         // set by bus writes only
    logic [31:0] lcg_q;
    logic [31:0] rnd;
    logic [1:0]  ar_cnt;                // cycles left before arready
    logic [1:0]  aw_cnt;
    logic [1:0]  w_cnt;
    logic        aw_got;
    logic        w_got;
    logic [7:0]  wr_idx;
    logic [63:0] wr_data;
    logic        wr_fire;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign rnd     = lcg_next(lcg_q);
    assign arready = arvalid && !rvalid && (ar_cnt == 2'd0);
    assign awready = awvalid && !aw_got && (aw_cnt == 2'd0);
    assign wready  = wvalid && !w_got && (w_cnt == 2'd0);
    assign wr_fire = aw_got && w_got && !bvalid;    // both halves in
    assign rresp   = 2'b00;
    assign bresp   = 2'b00;

    // pattern from the full word index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {32'hface_0000 | 32'(i), ~(32'hface_0000 | 32'(i))};
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            lcg_q   <= SEED;
            ar_cnt  <= 2'd0;
            aw_cnt  <= 2'd0;
            w_cnt   <= 2'd0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            rdata   <= '0;
            wr_idx  <= '0;
            wr_data <= '0;
            for (int i = 0; i < 256; i++) begin
                written[i] <= 1'b0;
            end
        end else begin
            lcg_q <= rnd;                           // one step per cycle
            // next stall 0..3 drawn while the channel is idle
            if (!arvalid) ar_cnt <= rnd[17:16];
            else if (ar_cnt != 2'd0) ar_cnt <= ar_cnt - 2'd1;
            if (!awvalid) aw_cnt <= rnd[17:16];
            else if (aw_cnt != 2'd0) aw_cnt <= aw_cnt - 2'd1;
            if (!wvalid) w_cnt <= rnd[21:20];
            else if (w_cnt != 2'd0) w_cnt <= w_cnt - 2'd1;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rdata  <= mem[araddr[10:3]];
            end
            if (rvalid && rready) rvalid <= 1'b0;
            if (awvalid && awready) begin
                aw_got <= 1'b1;
                wr_idx <= awaddr[10:3];
            end
            if (wvalid && wready) begin
                w_got   <= 1'b1;
                wr_data <= wdata;
            end
            if (wr_fire) begin
                bvalid          <= 1'b1;
                aw_got          <= 1'b0;
                w_got           <= 1'b0;
                written[wr_idx] <= 1'b1;
            end
            if (bvalid && bready) bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) mem[wr_idx] <= wr_data;        // wstrb always full
        else if (preload_we) mem[preload_addr] <= preload_data;
    end

endmodule

//--- bench/rv_tb.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_tb;
    localparam int ROM_WORDS  = 256;
    localparam int HROM_WORDS = 16;
    localparam int N_TESTS    = 5;
    localparam int WATCHDOG   = N_TESTS * 200 + ROM_WORDS + HROM_WORDS;
    localparam logic [31:0] SENT_SD = 32'h7e00_3c23;    // sd x0, 0x7f8(x0)
    localparam logic [7:0]  SENT_IDX = 8'hff;

    logic        clk = 1'b0;
    logic        reset;
    logic [63:0] imem_addr;
    logic [31:0] imem_data;
    logic        irq;
    logic        irq_ack;
    logic [63:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [63:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [63:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic        preload_we;
    logic [7:0]  preload_addr;
    logic [63:0] preload_data;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] hrom [HROM_WORDS];     // handler at mtvec
    int          rom_ptr;
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          ack_count = 0;
    logic [19:0] hi_a [20];
    logic [11:0] lo_a [20];
    logic [19:0] hi_b [20];
    logic [11:0] lo_b [20];
    logic [63:0] rom_off;
    logic [63:0] hrom_off;

    always #5 clk = ~clk;

    rv_top rv_top_inst (
        .clk, .reset, .imem_addr, .imem_data, .irq, .irq_ack,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready
    );

    rv_axil_ram #(.SEED(32'd56)) rv_axil_ram_inst (
        .clk, .reset, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .preload_we, .preload_addr, .preload_data
    );

    // combinational instruction rom, anything unmapped is the end store
    assign rom_off  = imem_addr - `RV_RESET_PC;
    assign hrom_off = imem_addr - `RV_TRAP_BASE;
    always_comb begin
        if (imem_addr >= `RV_RESET_PC && rom_off < 64'(4 * ROM_WORDS))
            imem_data = rom[rom_off[9:2]];
        else if (imem_addr >= `RV_TRAP_BASE && hrom_off < 64'(4 * HROM_WORDS))
            imem_data = hrom[hrom_off[5:2]];
        else
            imem_data = SENT_SD;
    end

    always @(posedge clk) if (irq_ack) ack_count <= ack_count + 1;

    // every accepted write beat carries all eight byte lanes
    always @(negedge clk) begin
        if (wvalid && wready) check_value("wstrb", 64'hff, 64'(wstrb));
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: the program never reached its end-of-test store");
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] ld_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] csrrw_word(input logic [4:0] rd, input logic [11:0] csr,
                                               input logic [4:0] rs1);
        return {csr, rs1, 3'b001, rd, 7'b1110011};
    endfunction

    function automatic logic [31:0] mret_word();
        return {`RV_FUNCT12_MRET, 5'd0, 3'b000, 5'd0, 7'b1110011};
    endfunction

    // lui hi then addi lo on top of base, rv64 sign extension
    function automatic logic [63:0] ref_sum(input logic [63:0] base, input logic [19:0] hi,
                                            input logic [11:0] lo);
        logic [63:0] upper;
        logic [63:0] lower;
        upper = {{32{hi[19]}}, hi, 12'h000};
        lower = {{52{lo[11]}}, lo};
        return base + upper + lower;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng = lcg_next(rng);
        v   = rng;
    endtask

    task automatic emit(input logic [31:0] word);
        rom[rom_ptr] = word;
        rom_ptr++;
    endtask

    task automatic fill_rom();
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = SENT_SD;
        for (int i = 0; i < HROM_WORDS; i++) hrom[i] = SENT_SD;
        rom_ptr = 0;
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_stored(input string name, input logic [63:0] addr,
                                input logic [63:0] exp);
        logic [7:0] idx;
        idx = addr[10:3];
        if (!rv_axil_ram_inst.written[idx]) begin
            $display("%s: nothing was ever stored at address %h", name, addr);
            errors++;
        end else begin
            check_value(name, exp, rv_axil_ram_inst.mem[idx]);
        end
    endtask

    task automatic hold_reset();
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic release_reset();
        @(posedge clk);
        reset <= 1'b1;
    endtask

    task automatic wait_sentinel();
        @(negedge clk);
        while (!rv_axil_ram_inst.written[SENT_IDX]) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) $display("%s: ok", name);
        else $display("%s: %0d mismatches", name, errors - start_errors);
    endtask

    initial begin
        logic [31:0] r;
        logic [63:0] word;
        logic [11:0] imm;
        logic [63:0] run_start;
        logic [63:0] epc;
        logic        in_run;
        int          t0;
        int          delay;
        int          acks_before;
        reset        = 1'b0;
        irq          = 1'b0;
        preload_we   = 1'b0;
        preload_addr = '0;
        preload_data = '0;
        rng          = 32'd56;
        errors       = 0;
        checks       = 0;
        fill_rom();

        // reset values, first fetch address
        t0 = errors;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_value("reset imem_addr", `RV_RESET_PC, imem_addr);
        check_value("reset irq_ack", 64'd0, 64'(irq_ack));
        check_value("reset valids", 64'd0, 64'({arvalid, awvalid, wvalid, rready, bready}));
        report_test("reset", t0);

        // lui/addi/add chains
        t0 = errors;
        hold_reset();
        fill_rom();
        for (int i = 0; i < 20; i++) begin
            draw(r);
            hi_a[i] = r[31:12];
            lo_a[i] = r[11:0];
            draw(r);
            hi_b[i] = r[31:12];
            lo_b[i] = r[11:0];
            emit(lui_word(5'd1, hi_a[i]));
            emit(addi_word(5'd1, 5'd1, lo_a[i]));
            emit(lui_word(5'd2, hi_b[i]));
            emit(addi_word(5'd2, 5'd2, lo_b[i]));
            emit(add_word(5'd3, 5'd1, 5'd2));
            emit(sd_word(5'd3, 5'd0, 12'h400 + 12'(8 * i)));
        end
        release_reset();
        wait_sentinel();
        for (int i = 0; i < 20; i++) begin
            check_stored("arith", 64'h400 + 64'(8 * i),
                         ref_sum(ref_sum(64'd0, hi_a[i], lo_a[i]), hi_b[i], lo_b[i]));
        end
        report_test("arith", t0);

        // ld then addi then sd, ram stalls at random
        t0 = errors;
        hold_reset();
        fill_rom();
        draw(r);
        word[63:32] = r;
        draw(r);
        word[31:0] = r;
        draw(r);
        imm = r[11:0];
        preload_we   <= 1'b1;
        preload_addr <= 8'h60;                  // byte address 0x300
        preload_data <= word;
        @(posedge clk);
        preload_we <= 1'b0;
        emit(ld_word(5'd3, 5'd0, 12'h300));
        emit(addi_word(5'd4, 5'd3, imm));
        emit(sd_word(5'd4, 5'd0, 12'h200));
        release_reset();
        wait_sentinel();
        check_stored("load", 64'h200, ref_sum(word, 20'h0, imm));
        report_test("load", t0);

        // x0 ignores writes
        t0 = errors;
        hold_reset();
        fill_rom();
        draw(r);
        emit(addi_word(5'd0, 5'd0, r[11:0] | 12'h001));
        emit(add_word(5'd6, 5'd0, 5'd0));
        emit(sd_word(5'd6, 5'd0, 12'h200));
        release_reset();
        wait_sentinel();
        check_stored("x0", 64'h200, 64'd0);
        report_test("x0", t0);

        // interrupt in the middle of 30 increments
        t0 = errors;
        hold_reset();
        fill_rom();
        emit(addi_word(5'd1, 5'd0, 12'h100));
        emit(csrrw_word(5'd0, `RV_CSR_MTVEC, 5'd1));
        emit(addi_word(5'd2, 5'd0, 12'h008));  // mstatus.mie
        emit(csrrw_word(5'd0, `RV_CSR_MSTATUS, 5'd2));
        run_start = `RV_RESET_PC + 64'(4 * rom_ptr);
        repeat (30) emit(addi_word(5'd5, 5'd5, 12'h001));
        emit(sd_word(5'd5, 5'd0, 12'h200));
        hrom[0] = csrrw_word(5'd7, `RV_CSR_MEPC, 5'd0);
        hrom[1] = csrrw_word(5'd0, `RV_CSR_MEPC, 5'd7);   // put mepc back
        hrom[2] = sd_word(5'd7, 5'd0, 12'h208);
        hrom[3] = mret_word();
        draw(r);
        delay = int'(r[20:16]) % 24;
        acks_before = ack_count;
        release_reset();
        @(negedge clk);
        while (imem_addr != run_start) @(negedge clk);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        irq <= 1'b1;
        @(negedge clk);
        while (!irq_ack) @(negedge clk);
        @(posedge clk);
        irq <= 1'b0;
        wait_sentinel();
        check_value("irq ack count", 64'd1, 64'(ack_count - acks_before));
        check_stored("irq x5", 64'h200, 64'd30);
        if (!rv_axil_ram_inst.written[8'h41]) begin
            $display("irq mepc: the handler never stored mepc");
            errors++;
        end else begin
            epc    = rv_axil_ram_inst.mem[8'h41];
            in_run = (epc[1:0] == 2'b00) && (epc >= run_start)
                     && (epc <= run_start + 64'(4 * 29));
            check_value("irq mepc in run", 64'd1, 64'(in_run));
        end
        report_test("irq", t0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_mem_if.sv
hdl/rv_regfile.sv
hdl/rv_csr.sv
hdl/rv_core.sv
hdl/rv_axil_master.sv
hdl/rv_top.sv
bench/rv_axil_ram.sv
bench/rv_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' tb.f) hdl/rv_defines.svh

.PHONY: all run clean

all: run

obj_dir/Vrv_tb: tb.f $(SRCS)
	verilator --binary -j 0 --top-module rv_tb -f tb.f -o Vrv_tb

run: obj_dir/Vrv_tb
	./obj_dir/Vrv_tb > sim.log; cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
